// ==== pe.f ====
source/pe_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/operand_stage.sv
source/vector_alu.sv
source/hazard_unit.sv
source/pe_top.sv
verif/pe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pe_tb -f pe.f -o pe_sim
./obj_dir/pe_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "Run ended without a result, see sim.log"
    exit 1
fi
echo "Run passed"

// ==== verif/pe_tb.sv ====
module pe_tb;
    import pe_pkg::*;

    localparam int DEPTH    = 32;
    localparam int PROG_MAX = 1 << PC_W;
    localparam logic [7:0] SWZ_ID  = 8'hE4;
    localparam logic [7:0] SWZ_REV = 8'h1B;
    localparam logic [31:0] MIX_A [4] = '{32'h3FC0_0000, 32'hC000_0000, 32'h0, 32'h8000_0000};
    localparam logic [31:0] MIX_B [4] = '{32'hBFC0_0000, 32'h4000_0000, 32'h8000_0000, 32'h0};
    localparam logic [31:0] SAT_V [4] = '{32'hBF00_0000, 32'h4000_0000, 32'h3F00_0000, FP_ONE};

    logic                  clk;
    logic                  reset_i;
    logic [INSTR_W-1:0]    instr_i;
    logic [PC_W-1:0]       instr_addr_o;
    logic                  wb_en_o;
    logic                  wb_bank_o;
    logic [REG_ADDR_W-1:0] wb_addr_o;
    logic [NUM_LANES-1:0]  wb_mask_o;
    logic [VEC_W-1:0]      wb_data_o;

    logic [INSTR_W-1:0]    imem [PROG_MAX];
    logic [VEC_W-1:0]      model_regs [NUM_BANKS][DEPTH];
    logic                  exp_bank_q [$];
    logic [REG_ADDR_W-1:0] exp_addr_q [$];
    logic [NUM_LANES-1:0]  exp_mask_q [$];
    logic [VEC_W-1:0]      exp_data_q [$];
    logic [31:0]           lfsr_state;
    logic [PC_W-1:0]       last_pc;
    int                    prog_len, first_write, cycle, wb_count, errors;
    bit                    prog_ready;

    pe_top #(.REG_DEPTH(DEPTH)) DUT (
        .clk(clk), .reset_i(reset_i), .instr_i(instr_i), .instr_addr_o(instr_addr_o),
        .wb_en_o(wb_en_o), .wb_bank_o(wb_bank_o), .wb_addr_o(wb_addr_o),
        .wb_mask_o(wb_mask_o), .wb_data_o(wb_data_o)
    );

    assign instr_i = imem[instr_addr_o];                 // Asynchronous ROM behavior

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [5:0] param_reg(input int n);
        return {1'b0, n[4:0]};
    endfunction

    function automatic logic [5:0] temp_reg(input int n);
        return {1'b1, n[4:0]};
    endfunction

    // Small address range so that random code runs into hazards often
    function automatic logic [5:0] pick_reg();
        logic [31:0] t;
        t = take_bits(3);
        return {t[2], 3'b000, t[1:0]};
    endfunction

    function automatic logic [3:0] pick_op();
        logic [31:0] t;
        t = take_bits(3);
        case (t[2:0])
            3'd0:       return OP_MOV;
            3'd1, 3'd5: return OP_MOVI;
            3'd2, 3'd6: return OP_MAX;
            3'd3, 3'd7: return OP_MIN;
            default:    return OP_SGNJ;
        endcase
    endfunction

    function automatic logic [31:0] flip_sign(input logic [31:0] x, input logic neg,
                                              input logic abs_en);
        logic s;
        s = abs_en ? 1'b0 : x[31];
        return {s ^ neg, x[30:0]};
    endfunction

    // Maps sign-magnitude onto a signed line where -0 lands just below +0
    function automatic logic signed [32:0] order_key(input logic [31:0] x);
        logic signed [32:0] mag;
        mag = {2'b00, x[30:0]};
        if (x[31])
            return -mag - 33'sd1;
        return mag;
    endfunction

    function automatic logic [31:0] saturate_lane(input logic [31:0] x);
        if (x[31])
            return 32'h0;
        return (x > FP_ONE) ? FP_ONE : x;
    endfunction

    function automatic logic [VEC_W-1:0] gather_lanes(input logic [5:0] src,
                                                      input logic [7:0] swz);
        logic [VEC_W-1:0] v, r;
        v = model_regs[src[5]][src[4:0]];
        for (int l = 0; l < NUM_LANES; l++) begin
            r[32*l +: 32] = v[32*swz[2*l +: 2] +: 32];
        end
        return r;
    endfunction

    // Encodes one instruction and runs it on the in-order model
    task automatic emit(input logic [3:0] op, input logic [5:0] dst, input logic [5:0] s1,
                        input logic [5:0] s2, input logic [3:0] mods, input logic sat,
                        input logic [3:0] mask, input logic [7:0] swz1, input logic [31:0] hi);
        logic [VEC_W-1:0] a, b, res;
        logic [31:0]      x, y, r;
        imem[prog_len] = {hi, 16'h0, swz1, 26'h0, s2[4:0], s2[5], mask, sat, 8'h0,
                          mods[3], mods[2], 3'h0, mods[1], mods[0], 4'h0,
                          s1[4:0], s1[5], dst[4:0], dst[5], op};
        prog_len++;
        a = gather_lanes(s1, swz1);
        b = (op == OP_MOVI) ? {NUM_LANES{hi}} : gather_lanes(s2, hi[7:0]);
        for (int l = 0; l < NUM_LANES; l++) begin
            x = flip_sign(a[32*l +: 32], mods[0], mods[1]);
            y = flip_sign(b[32*l +: 32], mods[2], mods[3]);
            case (op)
                OP_MOVI: r = y;
                OP_MAX:  r = (order_key(y) > order_key(x)) ? y : x;
                OP_MIN:  r = (order_key(y) < order_key(x)) ? y : x;
                OP_SGNJ: r = {y[31], x[30:0]};
                default: r = x;
            endcase
            res[32*l +: 32] = sat ? saturate_lane(r) : r;
        end
        if ((op inside {OP_MOV, OP_MOVI, OP_MAX, OP_MIN, OP_SGNJ}) && (mask != 4'h0)) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (mask[l])
                    model_regs[dst[5]][dst[4:0]][32*l +: 32] = res[32*l +: 32];
            end
            exp_bank_q.push_back(dst[5]);
            exp_addr_q.push_back(dst[4:0]);
            exp_mask_q.push_back(mask);
            exp_data_q.push_back(res);
            if (first_write < 0)
                first_write = prog_len - 1;
        end
    endtask

    task automatic build_program();
        logic [31:0] t, u;
        logic [3:0]  op;
        logic [5:0]  d, s1, s2;
        // Idle start, an unknown opcode and an empty mask, none of which write
        emit(OP_NOP, param_reg(0), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'hF, SWZ_ID, 0);
        emit(OP_NOP, param_reg(1), param_reg(1), param_reg(1), 4'h0, 1'b0, 4'hF, SWZ_ID, 0);
        emit(4'hF, temp_reg(1), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'hF, SWZ_ID, 0);
        emit(OP_MOVI, temp_reg(7), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'h0, SWZ_ID, 1);
        for (int r = 0; r < 4; r++) begin
            t = take_bits(32);
            emit(OP_MOVI, param_reg(r), param_reg(r), param_reg(0), 4'h0, 1'b0, 4'hF, SWZ_ID, t);
        end
        for (int r = 0; r < 4; r++) begin
            t = take_bits(32);
            u = take_bits(4);
            emit(OP_MOVI, param_reg(r), param_reg(r), param_reg(0), 4'h0, 1'b0, u[3:0],
                 SWZ_ID, t);
        end
        for (int r = 0; r < 4; r++)
            emit(OP_MOV, temp_reg(r), param_reg(r), param_reg(r), 4'h0, 1'b0, 4'hF, SWZ_ID, 0);
        emit(OP_MOV, temp_reg(8), param_reg(0), param_reg(0), 4'b0001, 1'b0, 4'hF, SWZ_REV, 0);
        emit(OP_MOV, temp_reg(9), param_reg(1), param_reg(1), 4'b0010, 1'b0, 4'hF, 8'hAA, 0);
        emit(OP_MOV, temp_reg(10), param_reg(2), param_reg(2), 4'b0011, 1'b0, 4'hF, 8'h4E, 0);
        for (int i = 0; i < 6; i++) begin
            t = take_bits(10);
            emit(OP_MOV, temp_reg(8 + i), param_reg(i % 4), param_reg(0), {2'b00, t[9:8]},
                 1'b0, 4'hF, t[7:0], 0);
        end
        for (int l = 0; l < 4; l++) begin
            emit(OP_MOVI, param_reg(10), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'(1 << l),
                 SWZ_ID, MIX_A[l]);
            emit(OP_MOVI, param_reg(11), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'(1 << l),
                 SWZ_ID, MIX_B[l]);
        end
        emit(OP_MAX, temp_reg(12), param_reg(10), param_reg(11), 4'h0, 1'b0, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_MIN, temp_reg(13), param_reg(10), param_reg(11), 4'h0, 1'b0, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_SGNJ, temp_reg(14), param_reg(10), param_reg(11), 4'h0, 1'b0, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_MAX, temp_reg(15), param_reg(10), param_reg(10), 4'h0, 1'b0, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_MIN, temp_reg(16), param_reg(11), param_reg(10), 4'b0100, 1'b0, 4'hF,
             SWZ_REV, SWZ_ID);
        for (int i = 0; i < 9; i++) begin
            t = take_bits(6);
            u = take_bits(16);
            op = (i % 3 == 0) ? OP_MAX : (i % 3 == 1) ? OP_MIN : OP_SGNJ;
            emit(op, temp_reg(17), param_reg(10 + t[0]), param_reg(11 - t[1]), t[5:2], 1'b0,
                 4'hF, u[7:0], {24'h0, u[15:8]});
        end
        for (int l = 0; l < 4; l++)
            emit(OP_MOVI, param_reg(20), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'(1 << l),
                 SWZ_ID, SAT_V[l]);
        emit(OP_MOV, temp_reg(20), param_reg(20), param_reg(20), 4'h0, 1'b1, 4'hF, SWZ_ID, 0);
        emit(OP_MOV, temp_reg(21), param_reg(20), param_reg(20), 4'b0001, 1'b1, 4'hF, SWZ_ID, 0);
        emit(OP_MAX, temp_reg(22), param_reg(20), param_reg(10), 4'h0, 1'b1, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_MOVI, temp_reg(23), param_reg(0), param_reg(0), 4'h0, 1'b1, 4'hF, SWZ_ID,
             32'h7F80_0000);
        // Back-to-back dependent chain that alternates banks
        emit(OP_MOVI, param_reg(24), param_reg(0), param_reg(0), 4'h0, 1'b0, 4'hF, SWZ_ID,
             take_bits(32));
        emit(OP_MOV, temp_reg(24), param_reg(24), param_reg(24), 4'b0001, 1'b0, 4'hF, SWZ_ID, 0);
        emit(OP_MAX, param_reg(25), temp_reg(24), param_reg(24), 4'h0, 1'b0, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_SGNJ, temp_reg(25), param_reg(25), temp_reg(24), 4'h0, 1'b0, 4'hF, SWZ_REV, SWZ_ID);
        emit(OP_MIN, param_reg(24), temp_reg(25), param_reg(25), 4'h0, 1'b0, 4'hF, SWZ_ID, SWZ_ID);
        emit(OP_MOV, temp_reg(24), param_reg(24), param_reg(24), 4'h0, 1'b0, 4'h5, SWZ_ID, 0);
        for (int i = 0; i < 40; i++) begin
            t = take_bits(17);
            u = take_bits(32);
            op = pick_op();
            d = pick_reg();
            s1 = pick_reg();
            s2 = pick_reg();
            emit(op, d, s1, s2, t[3:0], t[4], t[8:5], t[16:9],
                 (op == OP_MOVI) ? u : {24'h0, u[7:0]});
        end
    endtask

    task automatic report_mismatch(input string name, input logic [VEC_W-1:0] got,
                                   input logic [VEC_W-1:0] exp);
        errors++;
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h (writeback %0d)",
                 name, got, exp, wb_count);
    endtask

    always @(posedge clk) begin
        if (reset_i)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    // The fetch address either holds under a stall or steps by one
    always @(negedge clk) begin
        if (cycle > 0) begin
            assert (instr_addr_o == last_pc || instr_addr_o == last_pc + 1'b1)
            else begin
                errors++;
                $display("CHECK FAILED instr_addr_o: got 0x%0h, expected 0x%0h or 0x%0h",
                         instr_addr_o, last_pc, last_pc + 1'b1);
            end
        end
        last_pc = instr_addr_o;
    end

    always @(negedge clk) begin
        if (wb_en_o === 1'b1) begin
            assert (exp_data_q.size() != 0)
            else begin
                errors++;
                $display("Writeback to bank %0d register %0d with no instruction left to complete",
                         wb_bank_o, wb_addr_o);
            end
            if (exp_data_q.size() != 0) begin
                if (wb_count == 0) begin
                    assert (cycle == first_write + 4)
                    else begin
                        errors++;
                        $display("First writeback came in cycle %0d after reset, not in cycle %0d",
                                 cycle, first_write + 4);
                    end
                end
                assert (wb_bank_o == exp_bank_q[0])
                else report_mismatch("wb_bank_o", wb_bank_o, exp_bank_q[0]);
                assert (wb_addr_o == exp_addr_q[0])
                else report_mismatch("wb_addr_o", wb_addr_o, exp_addr_q[0]);
                assert (wb_mask_o == exp_mask_q[0])
                else report_mismatch("wb_mask_o", wb_mask_o, exp_mask_q[0]);
                assert (wb_data_o == exp_data_q[0])
                else report_mismatch("wb_data_o", wb_data_o, exp_data_q[0]);
                void'(exp_bank_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(exp_mask_q.pop_front());
                void'(exp_data_q.pop_front());
            end
            wb_count++;
        end
    end

    initial begin
        wait (prog_ready);
        repeat (20 * prog_len) @(posedge clk);
        $display("Timeout: %0d instructions did not drain within %0d cycles",
                 prog_len, 20 * prog_len);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        lfsr_state = 32'h4c3c_d6c6;
        errors = 0;
        wb_count = 0;
        prog_len = 0;
        first_write = -1;
        for (int i = 0; i < PROG_MAX; i++)
            imem[i] = '0;                                // NOPs follow the program
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < DEPTH; r++)
                model_regs[b][r] = '0;
        end
        build_program();
        prog_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        while (exp_data_q.size() != 0 || instr_addr_o <= prog_len)
            @(negedge clk);
        repeat (8) @(negedge clk);                      // A stray write from the tail shows up here
        $display("Writebacks seen: %0d, errors: %0d", wb_count, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== source/pe_top.sv ====
module pe_top #(
    parameter int REG_DEPTH = 32
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [pe_pkg::INSTR_W-1:0]        instr_i,
    output logic [pe_pkg::PC_W-1:0]           instr_addr_o,
    output logic                              wb_en_o,
    output logic                              wb_bank_o,
    output logic [pe_pkg::REG_ADDR_W-1:0]     wb_addr_o,
    output logic [pe_pkg::NUM_LANES-1:0]      wb_mask_o,
    output logic [pe_pkg::VEC_W-1:0]          wb_data_o
);
    import pe_pkg::*;

    logic [INSTR_W-1:0]    instr_d;
    opcode_e               opc_r;
    opcode_e               opc_e;
    logic                  dst_bank_r, we_r, src1_bank_r, src2_bank_r, src2_used_r;
    logic [REG_ADDR_W-1:0] dst_addr_r, src1_addr_r, src2_addr_r;
    logic                  neg1_r, abs1_r, neg2_r, abs2_r, sat_r;
    logic [SWZ_W-1:0]      swz1_r, swz2_r;
    logic [NUM_LANES-1:0]  mask_r, mask_e;
    logic [LANE_W-1:0]     imm_r;
    logic [VEC_W-1:0]      rdata1, rdata2, op1_e, op2_e;
    logic                  sat_e, we_e, dst_bank_e;
    logic [REG_ADDR_W-1:0] dst_addr_e;
    logic                  stall, bubble;

    fetch_unit u_fetch (
        .clk(clk), .reset_i(reset_i), .stall_i(stall), .instr_i(instr_i),
        .instr_addr_o(instr_addr_o), .instr_d_o(instr_d)
    );

    decode_unit #(.REG_DEPTH(REG_DEPTH)) u_decode (
        .clk(clk), .reset_i(reset_i), .stall_i(stall), .instr_d_i(instr_d),
        .opcode_r_o(opc_r),
        .dst_bank_r_o(dst_bank_r), .dst_addr_r_o(dst_addr_r), .we_r_o(we_r),
        .src1_bank_r_o(src1_bank_r), .src1_addr_r_o(src1_addr_r),
        .src2_bank_r_o(src2_bank_r), .src2_addr_r_o(src2_addr_r),
        .src2_used_r_o(src2_used_r),
        .neg1_r_o(neg1_r), .abs1_r_o(abs1_r), .neg2_r_o(neg2_r), .abs2_r_o(abs2_r),
        .swz1_r_o(swz1_r), .swz2_r_o(swz2_r),
        .sat_r_o(sat_r), .mask_r_o(mask_r), .imm_r_o(imm_r)
    );

    reg_file #(.REG_DEPTH(REG_DEPTH)) u_reg_file (
        .clk(clk), .reset_i(reset_i),
        .rbank1_i(src1_bank_r), .raddr1_i(src1_addr_r), .rswz1_i(swz1_r),
        .rbank2_i(src2_bank_r), .raddr2_i(src2_addr_r), .rswz2_i(swz2_r),
        .we_i(wb_en_o), .wbank_i(wb_bank_o), .waddr_i(wb_addr_o),
        .wmask_i(wb_mask_o), .wdata_i(wb_data_o),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    operand_stage u_operand (
        .clk(clk), .reset_i(reset_i), .bubble_i(bubble),
        .opcode_r_i(opc_r), .dst_bank_r_i(dst_bank_r), .dst_addr_r_i(dst_addr_r),
        .we_r_i(we_r), .neg1_r_i(neg1_r), .abs1_r_i(abs1_r),
        .neg2_r_i(neg2_r), .abs2_r_i(abs2_r), .sat_r_i(sat_r),
        .mask_r_i(mask_r), .imm_r_i(imm_r), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .opcode_e_o(opc_e), .op1_e_o(op1_e), .op2_e_o(op2_e),
        .sat_e_o(sat_e), .mask_e_o(mask_e), .we_e_o(we_e),
        .dst_bank_e_o(dst_bank_e), .dst_addr_e_o(dst_addr_e)
    );

    vector_alu u_alu (
        .clk(clk), .reset_i(reset_i),
        .opcode_e_i(opc_e), .op1_e_i(op1_e), .op2_e_i(op2_e),
        .sat_e_i(sat_e), .mask_e_i(mask_e), .we_e_i(we_e),
        .dst_bank_e_i(dst_bank_e), .dst_addr_e_i(dst_addr_e),
        .wb_en_o(wb_en_o), .wb_bank_o(wb_bank_o), .wb_addr_o(wb_addr_o),
        .wb_mask_o(wb_mask_o), .wb_data_o(wb_data_o)
    );

    hazard_unit #(.REG_DEPTH(REG_DEPTH)) u_hazard (
        .clk(clk), .reset_i(reset_i),
        .src1_bank_i(src1_bank_r), .src1_addr_i(src1_addr_r),
        .src2_bank_i(src2_bank_r), .src2_addr_i(src2_addr_r), .src2_used_i(src2_used_r),
        .dst_bank_e_i(dst_bank_e), .dst_addr_e_i(dst_addr_e), .we_e_i(we_e),
        .dst_bank_w_i(wb_bank_o), .dst_addr_w_i(wb_addr_o), .we_w_i(wb_en_o),
        .stall_o(stall), .bubble_o(bubble)
    );

endmodule

// ==== source/hazard_unit.sv ====
module hazard_unit #(
    parameter int REG_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          src1_bank_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] src1_addr_i,
    input  logic                          src2_bank_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] src2_addr_i,
    input  logic                          src2_used_i,
    input  logic                          dst_bank_e_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] dst_addr_e_i,
    input  logic                          we_e_i,
    input  logic                          dst_bank_w_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] dst_addr_w_i,
    input  logic                          we_w_i,
    output logic                          stall_o,
    output logic                          bubble_o
);
    import pe_pkg::*;

    logic src1_live, src2_live, hit1, hit2;

    function automatic logic pending(input logic bank, input logic [REG_ADDR_W-1:0] addr,
                                     input logic we, input logic dbank,
                                     input logic [REG_ADDR_W-1:0] daddr);
        return we && (bank == dbank) && (addr == daddr);
    endfunction

    // Reads past the bank depth are constant zero and never wait on a write
    assign src1_live = (src1_addr_i < REG_DEPTH);
    assign src2_live = src2_used_i && (src2_addr_i < REG_DEPTH);

    assign hit1 = src1_live &&
                  (pending(src1_bank_i, src1_addr_i, we_e_i, dst_bank_e_i, dst_addr_e_i) ||
                   pending(src1_bank_i, src1_addr_i, we_w_i, dst_bank_w_i, dst_addr_w_i));
    assign hit2 = src2_live &&
                  (pending(src2_bank_i, src2_addr_i, we_e_i, dst_bank_e_i, dst_addr_e_i) ||
                   pending(src2_bank_i, src2_addr_i, we_w_i, dst_bank_w_i, dst_addr_w_i));

    assign stall_o  = hit1 || hit2;
    assign bubble_o = stall_o;                           // Every held cycle sends a NOP to execute

    // The producer leaves writeback two cycles after the consumer first waits
    a_stall_bounded: assert property (@(posedge clk) disable iff (reset_i)
        stall_o ##1 stall_o |=> !stall_o)
        else $error("stall held for more than two cycles");

endmodule

// ==== source/vector_alu.sv ====
module vector_alu (
    input  logic                          clk,
    input  logic                          reset_i,
    input  pe_pkg::opcode_e               opcode_e_i,
    input  logic [pe_pkg::VEC_W-1:0]      op1_e_i,
    input  logic [pe_pkg::VEC_W-1:0]      op2_e_i,
    input  logic                          sat_e_i,
    input  logic [pe_pkg::NUM_LANES-1:0]  mask_e_i,
    input  logic                          we_e_i,
    input  logic                          dst_bank_e_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] dst_addr_e_i,
    output logic                          wb_en_o,
    output logic                          wb_bank_o,
    output logic [pe_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [pe_pkg::NUM_LANES-1:0]  wb_mask_o,
    output logic [pe_pkg::VEC_W-1:0]      wb_data_o
);
    import pe_pkg::*;

    logic [VEC_W-1:0] res_d, res_q;
    logic             sat_q;

    // Sign-magnitude order, so -0 sorts below +0
    function automatic logic lane_lt(input logic [LANE_W-1:0] a, input logic [LANE_W-1:0] b);
        if (a[LANE_W-1] != b[LANE_W-1])
            return a[LANE_W-1];
        else if (a[LANE_W-1])
            return a[LANE_W-2:0] > b[LANE_W-2:0];
        else
            return a[LANE_W-2:0] < b[LANE_W-2:0];
    endfunction

    function automatic logic [LANE_W-1:0] clamp(input logic [LANE_W-1:0] v);
        if (v[LANE_W-1])
            return '0;
        else if (v > FP_ONE)
            return FP_ONE;
        else
            return v;
    endfunction

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [LANE_W-1:0] a, b, r, q;

        assign a = op1_e_i[i*LANE_W +: LANE_W];
        assign b = op2_e_i[i*LANE_W +: LANE_W];

        always_comb begin
            case (opcode_e_i)
                OP_MOVI: r = b;
                OP_MAX:  r = lane_lt(a, b) ? b : a;      // Ties keep operand 1
                OP_MIN:  r = lane_lt(b, a) ? b : a;
                OP_SGNJ: r = {b[LANE_W-1], a[LANE_W-2:0]};
                default: r = a;
            endcase
        end

        assign res_d[i*LANE_W +: LANE_W] = r;
        assign q = res_q[i*LANE_W +: LANE_W];
        assign wb_data_o[i*LANE_W +: LANE_W] = sat_q ? clamp(q) : q;
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            wb_en_o <= 1'b0;
        else
            wb_en_o <= we_e_i;
    end

    always_ff @(posedge clk) begin
        res_q     <= res_d;
        sat_q     <= sat_e_i;
        wb_bank_o <= dst_bank_e_i;
        wb_addr_o <= dst_addr_e_i;
        wb_mask_o <= mask_e_i;
    end

    a_no_nop_write: assert property (@(posedge clk) disable iff (reset_i)
        wb_en_o |-> ($past(opcode_e_i) != OP_NOP))
        else $error("writeback raised for a NOP");

endmodule

// ==== source/operand_stage.sv ====
module operand_stage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          bubble_i,
    input  pe_pkg::opcode_e               opcode_r_i,
    input  logic                          dst_bank_r_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] dst_addr_r_i,
    input  logic                          we_r_i,
    input  logic                          neg1_r_i,
    input  logic                          abs1_r_i,
    input  logic                          neg2_r_i,
    input  logic                          abs2_r_i,
    input  logic                          sat_r_i,
    input  logic [pe_pkg::NUM_LANES-1:0]  mask_r_i,
    input  logic [pe_pkg::LANE_W-1:0]     imm_r_i,
    input  logic [pe_pkg::VEC_W-1:0]      rdata1_i,
    input  logic [pe_pkg::VEC_W-1:0]      rdata2_i,
    output pe_pkg::opcode_e               opcode_e_o,
    output logic [pe_pkg::VEC_W-1:0]      op1_e_o,
    output logic [pe_pkg::VEC_W-1:0]      op2_e_o,
    output logic                          sat_e_o,
    output logic [pe_pkg::NUM_LANES-1:0]  mask_e_o,
    output logic                          we_e_o,
    output logic                          dst_bank_e_o,
    output logic [pe_pkg::REG_ADDR_W-1:0] dst_addr_e_o
);
    import pe_pkg::*;

    logic [VEC_W-1:0] src2;

    // Abs clears each lane sign before negate flips it
    function automatic logic [VEC_W-1:0] modify(input logic [VEC_W-1:0] v,
                                                input logic neg, input logic abs_en);
        logic [VEC_W-1:0] r;
        r = v;
        for (int i = 0; i < NUM_LANES; i++) begin
            r[i*LANE_W + LANE_W - 1] = (v[i*LANE_W + LANE_W - 1] & ~abs_en) ^ neg;
        end
        return r;
    endfunction

    assign src2 = (opcode_r_i == OP_MOVI) ? {NUM_LANES{imm_r_i}} : rdata2_i;

    always_ff @(posedge clk) begin
        if (reset_i || bubble_i) begin
            opcode_e_o <= OP_NOP;
            we_e_o     <= 1'b0;
        end else begin
            opcode_e_o <= opcode_r_i;
            we_e_o     <= we_r_i;
        end
    end

    always_ff @(posedge clk) begin
        op1_e_o      <= modify(rdata1_i, neg1_r_i, abs1_r_i);
        op2_e_o      <= modify(src2, neg2_r_i, abs2_r_i);
        sat_e_o      <= sat_r_i;
        mask_e_o     <= mask_r_i;
        dst_bank_e_o <= dst_bank_r_i;
        dst_addr_e_o <= dst_addr_r_i;
    end

endmodule

// ==== source/reg_file.sv ====
module reg_file #(
    parameter int REG_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          rbank1_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [pe_pkg::SWZ_W-1:0]      rswz1_i,
    input  logic                          rbank2_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] raddr2_i,
    input  logic [pe_pkg::SWZ_W-1:0]      rswz2_i,
    input  logic                          we_i,
    input  logic                          wbank_i,
    input  logic [pe_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [pe_pkg::NUM_LANES-1:0]  wmask_i,
    input  logic [pe_pkg::VEC_W-1:0]      wdata_i,
    output logic [pe_pkg::VEC_W-1:0]      rdata1_o,
    output logic [pe_pkg::VEC_W-1:0]      rdata2_o
);
    import pe_pkg::*;

    logic [VEC_W-1:0] regs [NUM_BANKS][REG_DEPTH];

    function automatic logic [VEC_W-1:0] swizzle(input logic [VEC_W-1:0] v,
                                                 input logic [SWZ_W-1:0] swz);
        logic [VEC_W-1:0] r;
        for (int i = 0; i < NUM_LANES; i++) begin
            r[i*LANE_W +: LANE_W] = v[swz[i*SEL_W +: SEL_W]*LANE_W +: LANE_W];
        end
        return r;
    endfunction

    // Addresses past the bank depth read as zero
    assign rdata1_o = swizzle((raddr1_i < REG_DEPTH) ? regs[rbank1_i][raddr1_i] : '0, rswz1_i);
    assign rdata2_o = swizzle((raddr2_i < REG_DEPTH) ? regs[rbank2_i][raddr2_i] : '0, rswz2_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int r = 0; r < REG_DEPTH; r++) begin
                    regs[b][r] <= '0;
                end
            end
        end else if (we_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wmask_i[l]) begin
                    regs[wbank_i][waddr_i][l*LANE_W +: LANE_W] <= wdata_i[l*LANE_W +: LANE_W];
                end
            end
        end
    end

endmodule

// ==== source/decode_unit.sv ====
module decode_unit #(
    parameter int REG_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          stall_i,
    input  logic [pe_pkg::INSTR_W-1:0]    instr_d_i,
    output pe_pkg::opcode_e               opcode_r_o,
    output logic                          dst_bank_r_o,
    output logic [pe_pkg::REG_ADDR_W-1:0] dst_addr_r_o,
    output logic                          we_r_o,
    output logic                          src1_bank_r_o,
    output logic [pe_pkg::REG_ADDR_W-1:0] src1_addr_r_o,
    output logic                          src2_bank_r_o,
    output logic [pe_pkg::REG_ADDR_W-1:0] src2_addr_r_o,
    output logic                          src2_used_r_o,
    output logic                          neg1_r_o,
    output logic                          abs1_r_o,
    output logic                          neg2_r_o,
    output logic                          abs2_r_o,
    output logic [pe_pkg::SWZ_W-1:0]      swz1_r_o,
    output logic [pe_pkg::SWZ_W-1:0]      swz2_r_o,
    output logic                          sat_r_o,
    output logic [pe_pkg::NUM_LANES-1:0]  mask_r_o,
    output logic [pe_pkg::LANE_W-1:0]     imm_r_o
);
    import pe_pkg::*;

    logic [OPC_W-1:0]      opc_raw;
    opcode_e               opc_d;
    logic [REG_ADDR_W-1:0] dst_addr_d;
    logic [NUM_LANES-1:0]  mask_d;
    logic                  we_d;

    assign opc_raw    = instr_d_i[OPC_LSB +: OPC_W];
    assign dst_addr_d = instr_d_i[DST_ADDR_LSB +: REG_ADDR_W];
    assign mask_d     = instr_d_i[MASK_LSB +: NUM_LANES];

    always_comb begin
        case (opc_raw)
            OP_MOV, OP_MOVI, OP_MAX, OP_MIN, OP_SGNJ: opc_d = opcode_e'(opc_raw);
            default: opc_d = OP_NOP;                     // Unknown codes are dropped here
        endcase
    end

    // A write with no lanes or beyond the bank depth is not a write at all
    assign we_d = (opc_d != OP_NOP) && (mask_d != '0) && (dst_addr_d < REG_DEPTH);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            opcode_r_o <= OP_NOP;
            we_r_o     <= 1'b0;
        end else if (!stall_i) begin
            opcode_r_o <= opc_d;
            we_r_o     <= we_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            dst_bank_r_o  <= instr_d_i[DST_BANK_BIT];
            dst_addr_r_o  <= dst_addr_d;
            src1_bank_r_o <= instr_d_i[SRC1_BANK_BIT];
            src1_addr_r_o <= instr_d_i[SRC1_ADDR_LSB +: REG_ADDR_W];
            src2_bank_r_o <= instr_d_i[SRC2_BANK_BIT];
            src2_addr_r_o <= instr_d_i[SRC2_ADDR_LSB +: REG_ADDR_W];
            src2_used_r_o <= (opc_d != OP_MOVI);         // MOVI takes the immediate instead
            neg1_r_o      <= instr_d_i[NEG1_BIT];
            abs1_r_o      <= instr_d_i[ABS1_BIT];
            neg2_r_o      <= instr_d_i[NEG2_BIT];
            abs2_r_o      <= instr_d_i[ABS2_BIT];
            swz1_r_o      <= instr_d_i[SWZ1_LSB +: SWZ_W];
            swz2_r_o      <= instr_d_i[SWZ2_LSB +: SWZ_W];
            sat_r_o       <= instr_d_i[SAT_BIT];
            mask_r_o      <= mask_d;
            imm_r_o       <= instr_d_i[IMM_LSB +: LANE_W];
        end
    end

    a_we_has_lanes: assert property (@(posedge clk) disable iff (reset_i)
        we_r_o |-> (mask_r_o != '0))
        else $error("write enable decoded with an empty lane mask");

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       stall_i,
    input  logic [pe_pkg::INSTR_W-1:0] instr_i,
    output logic [pe_pkg::PC_W-1:0]    instr_addr_o,
    output logic [pe_pkg::INSTR_W-1:0] instr_d_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            instr_addr_o <= '0;
            instr_d_o    <= '0;                          // All-zero word decodes as NOP
        end else if (!stall_i) begin
            instr_addr_o <= instr_addr_o + 1'b1;
            instr_d_o    <= instr_i;                     // Memory answers in the same cycle
        end
    end

endmodule

// ==== source/pe_pkg.sv ====
package pe_pkg;

    localparam int LANE_W     = 32;
    localparam int NUM_LANES  = 4;
    localparam int VEC_W      = LANE_W * NUM_LANES;
    localparam int INSTR_W    = 128;
    localparam int PC_W       = 10;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_BANKS  = 2;                       // Bank 0 holds parameters, bank 1 temporaries
    localparam int SEL_W      = $clog2(NUM_LANES);
    localparam int SWZ_W      = SEL_W * NUM_LANES;       // Lane 0 selector in the lowest pair
    localparam int OPC_W      = 4;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'd0,
        OP_MOV  = 4'd1,
        OP_MOVI = 4'd2,
        OP_MAX  = 4'd3,
        OP_MIN  = 4'd4,
        OP_SGNJ = 4'd5
    } opcode_e;

    localparam int OPC_LSB       = 0;
    localparam int DST_BANK_BIT  = 4;
    localparam int DST_ADDR_LSB  = 5;
    localparam int SRC1_BANK_BIT = 10;
    localparam int SRC1_ADDR_LSB = 11;
    localparam int SRC2_BANK_BIT = 40;
    localparam int SRC2_ADDR_LSB = 41;
    localparam int NEG1_BIT      = 20;
    localparam int ABS1_BIT      = 21;
    localparam int NEG2_BIT      = 25;
    localparam int ABS2_BIT      = 26;
    localparam int SAT_BIT       = 35;
    localparam int MASK_LSB      = 36;                   // Bit n enables lane n
    localparam int SWZ1_LSB      = 72;
    localparam int SWZ2_LSB      = 96;
    localparam int IMM_LSB       = 96;                   // Shares bits with swizzle 2, MOVI only

    localparam logic [LANE_W-1:0] FP_ONE = 32'h3F80_0000;

endpackage
